// ==== rtl/das_pkg.sv ====
// ======================================================================
// DAS input panel shared definitions: lane count, debounce and LED
// timing, per-lane delayed auto shift table, and common types.
// ======================================================================
`default_nettype none

package das_pkg;

    localparam int KEY_COUNT       = 4;
    localparam int SYNC_STAGES     = 2;
    localparam int DEBOUNCE_CYCLES = 5;   // Consecutive disagreeing cycles before a flip.
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);
    localparam int LED_HOLD_CYCLES = 12;
    localparam int DAS_CNT_W       = 24;

    // Cycle count for the DAS timer and the LED stretch counter.
    typedef logic [DAS_CNT_W-1:0] das_count_t;

    // One bit per key lane.
    typedef logic [KEY_COUNT-1:0] lane_mask_t;

    typedef struct packed {
        das_count_t cd_long;    // First strobe to second strobe.
        das_count_t cd_short;   // Between later repeats.
    } das_timing_t;

    // Simulation-scale timing. A board build only needs larger values here.
    localparam das_timing_t DAS_TIMING [KEY_COUNT] = '{
        '{cd_long: das_count_t'(40), cd_short: das_count_t'(10)},
        '{cd_long: das_count_t'(40), cd_short: das_count_t'(12)},
        '{cd_long: das_count_t'(40), cd_short: das_count_t'(14)},
        '{cd_long: das_count_t'(40), cd_short: das_count_t'(16)}
    };

    typedef enum logic [1:0] {
        DAS_IDLE,     // Key released.
        DAS_DELAY,    // Waiting out cd_long after the first strobe.
        DAS_REPEAT    // Strobing every cd_short.
    } das_state_e;

    typedef struct packed {
        lane_mask_t action;   // One-cycle move strobes.
        lane_mask_t led;      // Stretched strobe indicators.
    } panel_out_t;

endpackage

`default_nettype wire

// ==== rtl/key_conditioner.sv ====
// ======================================================================
// Key conditioner: synchronizes one raw key level into the clock domain
// and filters out bounce shorter than DEBOUNCE_CYCLES.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module key_conditioner
    import das_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic key_raw,    // High means pressed. Asynchronous to clk.
    output logic pressed
);

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   key_sync;
    logic [DEBOUNCE_W-1:0]  agree_cnt;
    logic                   differs;

    // The oldest stage is the settled copy of the key.
    assign key_sync = sync_q[SYNC_STAGES-1];
    assign differs  = (key_sync != pressed);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], key_raw};
        end
    end

    // Count consecutive cycles of disagreement between the synchronized
    // key and the filtered level. Any agreeing cycle starts the count over,
    // so a glitch must outlast the whole window to be accepted.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            agree_cnt <= '0;
            pressed   <= 1'b0;
        end else if (differs) begin
            if (agree_cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1)) begin
                pressed   <= key_sync;   // Level accepted on the last disagreeing cycle.
                agree_cnt <= '0;
            end else begin
                agree_cnt <= agree_cnt + 1'b1;
            end
        end else begin
            agree_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/das_fsm.sv ====
// ======================================================================
// Delayed auto shift machine: one strobe on press, a second after
// cd_long, then a strobe every cd_short until the key is released.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module das_fsm
    import das_pkg::*;
#(
    parameter das_timing_t TIMING = DAS_TIMING[0]
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pressed,   // Debounced key level.
    output logic action     // One-cycle move strobe.
);

    das_state_e state_q;
    das_state_e state_d;
    das_count_t timer_q;
    das_count_t timer_d;
    logic       action_d;
    logic       timer_done;

    // The timer is loaded with the period minus one so that the strobe
    // lands exactly one period after the previous strobe.
    das_count_t long_load;
    das_count_t short_load;

    assign long_load  = TIMING.cd_long - 1'b1;
    assign short_load = TIMING.cd_short - 1'b1;
    assign timer_done = (timer_q == '0);

    always_comb begin
        state_d  = state_q;
        timer_d  = timer_q;
        action_d = 1'b0;

        if (!pressed) begin
            // Release cancels anything still scheduled.
            state_d = DAS_IDLE;
            timer_d = '0;
        end else begin
            case (state_q)
                DAS_IDLE: begin
                    // Any high level here is a new press, since a low always
                    // brings the machine back to idle.
                    action_d = 1'b1;
                    timer_d  = long_load;
                    state_d  = DAS_DELAY;
                end

                DAS_DELAY,
                DAS_REPEAT: begin
                    if (timer_done) begin
                        action_d = 1'b1;
                        timer_d  = short_load;
                        state_d  = DAS_REPEAT;
                    end else begin
                        timer_d = timer_q - 1'b1;   // Count down toward the next strobe.
                    end
                end

                default: begin
                    state_d = DAS_IDLE;
                    timer_d = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= DAS_IDLE;
            timer_q <= '0;
            action  <= 1'b0;
        end else begin
            state_q <= state_d;
            timer_q <= timer_d;
            action  <= action_d;   // Registered, so T0 is the cycle after the press.
        end
    end

endmodule

`default_nettype wire

// ==== rtl/led_stretcher.sv ====
// ======================================================================
// LED stretcher: turns a one-cycle strobe into an LED level that holds
// for LED_HOLD_CYCLES cycles.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module led_stretcher
    import das_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic strobe,
    output logic led
);

    das_count_t hold_cnt;
    logic       hold_active;
    logic       hold_last;

    assign hold_active = (hold_cnt != '0);
    assign hold_last   = (hold_cnt == das_count_t'(LED_HOLD_CYCLES));

    // The counter runs from 1 up to LED_HOLD_CYCLES. Strobes seen while it
    // is running neither restart nor extend the hold.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (hold_active) begin
            if (hold_last) begin
                hold_cnt <= '0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end else if (strobe) begin
            hold_cnt <= das_count_t'(1);   // Start a new hold.
        end
    end

    // The LED is lit exactly while a hold is in progress.
    assign led = hold_active;

endmodule

`default_nettype wire

// ==== rtl/das_input_panel.sv ====
// ======================================================================
// DAS input panel: four key lanes, each a conditioner, a delayed auto
// shift machine and an LED stretcher, with strobes and LEDs brought out.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module das_input_panel
    import das_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  lane_mask_t key_n,    // Raw active-low keys.
    output panel_out_t status
);

    lane_mask_t key_raw;
    lane_mask_t pressed;
    lane_mask_t action;
    lane_mask_t led;

    // Buttons pull low when pressed. The lanes work with high as pressed.
    assign key_raw = ~key_n;

    for (genvar g = 0; g < KEY_COUNT; g++) begin : lane_g
        key_conditioner key_conditioner_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .key_raw (key_raw[g]),
            .pressed (pressed[g])
        );

        // Lanes differ only in their entry of the timing table.
        das_fsm #(
            .TIMING (DAS_TIMING[g])
        ) das_fsm_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .pressed (pressed[g]),
            .action  (action[g])
        );

        led_stretcher led_stretcher_inst (
            .clk    (clk),
            .rst_n  (rst_n),
            .strobe (action[g]),
            .led    (led[g])
        );
    end

    assign status.action = action;
    assign status.led    = led;

endmodule

`default_nettype wire

// ==== tests/das_input_panel_chk.sv ====
// ======================================================================
// Bound assertions for the DAS input panel: strobe width, LED hold
// length and output values right after reset.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module das_input_panel_chk
    import das_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_n,
    input wire panel_out_t status
);

    // Cycle after reset must show a quiet panel.
    assert property (@(posedge clk) !rst_n |=> status == '0)
        else $error("status not zero in the cycle after reset");

    for (genvar g = 0; g < KEY_COUNT; g++) begin : lane_g
        int led_run;   // Consecutive cycles this LED has been lit.

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                led_run <= 0;
            end else if (status.led[g]) begin
                led_run <= led_run + 1;
            end else begin
                led_run <= 0;
            end
        end

        assert property (@(posedge clk) disable iff (!rst_n)
                         status.action[g] |=> !status.action[g])
            else $error("lane %0d action high on two consecutive cycles", g);

        assert property (@(posedge clk) disable iff (!rst_n)
                         $fell(status.led[g]) |-> led_run == LED_HOLD_CYCLES)
            else $error("lane %0d LED hold was %0d cycles", g, led_run);

        assert property (@(posedge clk) disable iff (!rst_n) led_run <= LED_HOLD_CYCLES)
            else $error("lane %0d LED held too long", g);
    end

endmodule

bind das_input_panel das_input_panel_chk chk_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .status (status)
);

`default_nettype wire

// ==== tests/das_input_panel_tb.sv ====
// ======================================================================
// Testbench for the DAS input panel: drives key presses, predicts
// strobes and LEDs per lane and compares them every cycle.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module das_input_panel_tb;
    import das_pkg::*;

    localparam int FIRST_LAT = SYNC_STAGES + DEBOUNCE_CYCLES + 1;   // Key edge to first strobe.

    logic       clk;
    logic       rst_n;
    lane_mask_t key_n;
    panel_out_t status;

    int          cyc;
    int          errors;
    int          tests;
    int          test_start_errors;
    logic [31:0] rng_state;
    int          pulse_times [KEY_COUNT][$];   // DUT strobe cycles per lane.
    int          ref_pulses [KEY_COUNT];

    // Reference model state with one entry per lane.
    logic m_hist1 [KEY_COUNT];
    logic m_hist2 [KEY_COUNT];
    logic m_p [KEY_COUNT];
    int   m_cnt [KEY_COUNT];
    int   m_rise [KEY_COUNT];
    logic m_act [KEY_COUNT];
    int   m_led [KEY_COUNT];

    das_input_panel das_input_panel_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .key_n  (key_n),
        .status (status)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int rand_range(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % n);
    endfunction

    // Advances one lane of the reference by one clock edge and returns
    // the expected {action, led} after that edge.
    function automatic logic [1:0] reference_step(input int l, input logic raw, input logic rst);
        int   cl;
        int   cs;
        int   t0;
        logic act;
        logic sync;
        cl = int'(DAS_TIMING[l].cd_long);
        cs = int'(DAS_TIMING[l].cd_short);
        if (!rst) begin
            m_hist1[l] = 1'b0;
            m_hist2[l] = 1'b0;
            m_p[l]     = 1'b0;
            m_cnt[l]   = 0;
            m_act[l]   = 1'b0;
            m_led[l]   = 0;
            return 2'b00;
        end
        // The stretcher sees the strobe of the previous cycle.
        if (m_led[l] != 0) begin
            m_led[l] = (m_led[l] == LED_HOLD_CYCLES) ? 0 : m_led[l] + 1;
        end else if (m_act[l]) begin
            m_led[l] = 1;
        end
        t0  = m_rise[l] + 1;
        act = m_p[l] && ((cyc == t0) || (cyc >= t0 + cl && (cyc - t0 - cl) % cs == 0));
        sync = m_hist2[l];   // Raw level two edges back.
        if (sync != m_p[l]) begin
            if (m_cnt[l] == DEBOUNCE_CYCLES - 1) begin
                m_p[l]   = sync;
                m_cnt[l] = 0;
                if (sync) m_rise[l] = cyc;
            end else begin
                m_cnt[l]++;
            end
        end else begin
            m_cnt[l] = 0;
        end
        m_hist2[l] = m_hist1[l];
        m_hist1[l] = raw;
        m_act[l]   = act;
        return {act, m_led[l] != 0};
    endfunction

    task automatic check_mask(input lane_mask_t got, input lane_mask_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input das_count_t got, input das_count_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // The model steps on the rising edge and the DUT is checked on the falling one.
    initial begin
        lane_mask_t exp_act;
        lane_mask_t exp_led;
        logic       rst_s;
        lane_mask_t raw_s;
        logic [1:0] r;
        forever begin
            @(posedge clk);
            cyc++;
            rst_s = rst_n;
            raw_s = ~key_n;
            for (int l = 0; l < KEY_COUNT; l++) begin
                r = reference_step(l, raw_s[l], rst_s);
                exp_act[l] = r[1];
                exp_led[l] = r[0];
                if (r[1]) ref_pulses[l]++;
            end
            @(negedge clk);
            check_mask(status.action, exp_act, "action");
            check_mask(status.led, exp_led, "led");
            for (int l = 0; l < KEY_COUNT; l++) begin
                if (status.action[l]) pulse_times[l].push_back(cyc);
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic set_key(input int l, input logic down);
        @(negedge clk);
        key_n[l] = ~down;
    endtask

    task automatic clear_records();
        for (int l = 0; l < KEY_COUNT; l++) begin
            pulse_times[l].delete();
            ref_pulses[l] = 0;
        end
    endtask

    task automatic wait_for_pulse(input int l, input int limit, output int at);
        int n;
        n  = 0;
        at = -1;
        while (at < 0 && n < limit) begin
            @(negedge clk);
            n++;
            if (status.action[l]) at = cyc;
        end
        if (at < 0) begin
            $display("timeout: lane %0d gave no strobe within %0d cycles", l, limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        int edge_cyc;
        int at;
        int left [KEY_COUNT];
        logic level [KEY_COUNT];
        cyc = 0;
        errors = 0;
        tests = 0;
        test_start_errors = 0;
        rng_state = 32'd37011;
        rst_n = 1'b0;
        key_n = '1;
        for (int l = 0; l < KEY_COUNT; l++) begin
            m_rise[l] = 0;
            ref_pulses[l] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset and idle.
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_mask(status.action, '0, "idle action");
            check_mask(status.led, '0, "idle led");
        end
        finish_test("reset");

        // Single tap on lane 0.
        clear_records();
        set_key(0, 1'b1);
        edge_cyc = cyc;
        wait_for_pulse(0, 30, at);
        check_count(das_count_t'(at - edge_cyc), das_count_t'(FIRST_LAT), "tap latency");
        idle(20 - FIRST_LAT - 1);
        set_key(0, 1'b0);
        idle(30);
        check_count(das_count_t'(pulse_times[0].size()), das_count_t'(1), "tap pulses");
        finish_test("single tap");

        // Auto shift on each lane.
        for (int l = 0; l < KEY_COUNT; l++) begin
            clear_records();
            set_key(l, 1'b1);
            idle(FIRST_LAT + 40 + 4 * int'(DAS_TIMING[l].cd_short) + 3);
            set_key(l, 1'b0);
            idle(40);
            check_count(das_count_t'(pulse_times[l].size()), das_count_t'(ref_pulses[l]),
                        "auto shift pulse count");
            for (int i = 1; i < pulse_times[l].size(); i++) begin
                check_count(das_count_t'(pulse_times[l][i] - pulse_times[l][i-1]),
                            (i == 1) ? DAS_TIMING[l].cd_long : DAS_TIMING[l].cd_short,
                            "auto shift interval");
            end
        end
        finish_test("auto shift");

        // Short glitches and then a bouncy press on lane 1.
        clear_records();
        for (int g = 1; g < DEBOUNCE_CYCLES; g++) begin
            set_key(1, 1'b1);
            idle(g - 1);
            set_key(1, 1'b0);
            idle(20);
        end
        check_count(das_count_t'(pulse_times[1].size()), das_count_t'(0), "glitch pulses");
        for (int i = 0; i < 6; i++) begin
            set_key(1, 1'b1);
            idle(rand_range(DEBOUNCE_CYCLES - 1));
            set_key(1, 1'b0);
            idle(rand_range(DEBOUNCE_CYCLES - 1));
        end
        set_key(1, 1'b1);
        edge_cyc = cyc;
        wait_for_pulse(1, 30, at);
        check_count(das_count_t'(at - edge_cyc), das_count_t'(FIRST_LAT), "bounce latency");
        idle(15);
        set_key(1, 1'b0);
        idle(30);
        check_count(das_count_t'(pulse_times[1].size()), das_count_t'(1), "bounce pulses");
        finish_test("debounce");

        // Lane 0 repeats faster than the LED hold and the compare process checks every cycle.
        set_key(0, 1'b1);
        idle(100);
        set_key(0, 1'b0);
        idle(30);
        finish_test("led retrigger");

        // Overlapping random presses on every lane.
        clear_records();
        for (int l = 0; l < KEY_COUNT; l++) begin
            left[l] = rand_range(20);
            level[l] = 1'b0;
        end
        for (int i = 0; i < 600; i++) begin
            @(negedge clk);
            for (int l = 0; l < KEY_COUNT; l++) begin
                if (left[l] == 0) begin
                    level[l] = ~level[l];
                    key_n[l] = ~level[l];
                    left[l] = rand_range(60) + 1;
                end else begin
                    left[l]--;
                end
            end
        end
        key_n = '1;
        idle(40);
        for (int l = 0; l < KEY_COUNT; l++) begin
            check_count(das_count_t'(pulse_times[l].size()), das_count_t'(ref_pulses[l]),
                        "random pulse count");
        end
        finish_test("concurrent lanes");

        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/das_pkg.sv
rtl/key_conditioner.sv
rtl/das_fsm.sv
rtl/led_stretcher.sv
rtl/das_input_panel.sv
tests/das_input_panel_chk.sv
tests/das_input_panel_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the DAS input panel testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module das_input_panel_tb -f list.f \
    -o das_input_panel_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/das_input_panel_sim 2>&1)"
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Done: no errors" && exit 0 || exit 1
